// ==== files.f ====
+incdir+include
hw/word_pkg.sv
hw/lane_pkg.sv
hw/lane_steer.sv
hw/lane_unit.sv
hw/lane_merge.sv
hw/xlane_top.sv
tb/tb_xlane.sv

// ==== hw/lane_merge.sv ====
/*
 * Priority fan-in of the lane beats into one stream.
 * Lower lanes win; the choice stays latched while that lane is valid.
 * The output register holds its word until accepted and carries
 * the winning lane as a one-hot tag.
 */

`timescale 1ns/1ps
`default_nettype none

`include "xlane_cfg.svh"

module lane_merge (
  input  logic                                         clk,
  input  logic                                         rst,
  input  lane_pkg::lane_oh_t                           beat_valid,
  output lane_pkg::lane_oh_t                           beat_ready,
  input  lane_pkg::lane_beat_t [`XLANE_NUM_LANES-1:0]  beats,
  output logic                                         out_valid,
  input  logic                                         out_ready,
  output logic [`XLANE_PAYLOAD_W-1:0]                  out_data,
  output lane_pkg::lane_oh_t                           out_lane
);

  import lane_pkg::*;

  localparam int N = `XLANE_NUM_LANES;

  lane_oh_t   sel;
  lane_oh_t   first_valid;
  lane_idx_t  sel_idx;
  logic       sel_valid;
  lane_beat_t sel_beat;
  logic       out_open;
  logic       load;

  ////////////////////////////////
  // select stage

  // isolate lowest valid lane
  assign first_valid = beat_valid & (~beat_valid + 1'b1);

  // held choice still has a beat
  assign sel_valid = |(sel & beat_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      sel <= '0;
    end else if (!sel_valid) begin
      // re-pick only once the chosen lane goes idle
      sel <= first_valid;
    end
  end

  // one-hot to index for the beat mux
  always_comb begin
    sel_idx = '0;
    for (int i = 0; i < N; i++) begin
      if (sel[i]) begin
        sel_idx = lane_idx_t'(i);
      end
    end
  end

  assign sel_beat = beats[sel_idx];

  ////////////////////////////////
  // output stage

  // room when empty or draining this edge
  assign out_open = ~out_valid | out_ready;
  assign load     = sel_valid & out_open;

  assign beat_ready = out_open ? sel : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (out_open) begin
      out_valid <= sel_valid;
    end
  end

  // word and tag stay put under back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= sel_beat.data;
      out_lane <= sel;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> out_valid && $stable(out_data) && $stable(out_lane));

endmodule

`default_nettype wire

// ==== hw/lane_pkg.sv ====
/*
 * Lane-side types shared by the steering, lane and merge stages.
 * The one-hot vector doubles as the output user tag.
 */

`default_nettype none

`include "xlane_cfg.svh"

package lane_pkg;

  // binary lane number
  typedef logic [`XLANE_LANE_W-1:0] lane_idx_t;

  // one bit per lane, used for valids, readies and the user tag
  typedef logic [`XLANE_NUM_LANES-1:0] lane_oh_t;

  // transformed word from a lane to the merge stage
  typedef struct packed {
    logic [`XLANE_PAYLOAD_W-1:0] data;
  } lane_beat_t;

endpackage

`default_nettype wire

// ==== hw/lane_steer.sv ====
/*
 * Input buffer and router. Holds one word, decodes its lane field
 * and offers it to that lane only; one word per cycle when drained.
 */

`timescale 1ns/1ps
`default_nettype none

`include "xlane_cfg.svh"

module lane_steer (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  word_pkg::in_word_t  in_word,
  output lane_pkg::lane_oh_t  lane_valid,
  input  lane_pkg::lane_oh_t  lane_ready,
  output word_pkg::in_word_t  lane_word
);

  import word_pkg::*;
  import lane_pkg::*;

  logic      live;
  logic      buf_full;
  in_word_t  buf_word;
  lane_idx_t buf_lane;
  lane_oh_t  lane_sel;
  logic      buf_take;

  ////////////////////////////////
  // lane decode

  assign buf_lane = buf_word.lane;

  always_comb begin
    lane_sel = '0;
    lane_sel[buf_lane] = 1'b1;
  end

  // offer only while holding a word
  assign lane_valid = buf_full ? lane_sel : '0;
  assign lane_word  = buf_word;

  // addressed lane takes it
  assign buf_take = |(lane_valid & lane_ready);

  // empty or emptying this edge
  assign in_ready = live & (~buf_full | buf_take);

  ////////////////////////////////
  // buffer state

  always_ff @(posedge clk) begin
    if (rst) begin
      live     <= 1'b0;
      buf_full <= 1'b0;
    end else begin
      live <= 1'b1;
      if (in_valid && in_ready) begin
        buf_full <= 1'b1;
      end else if (buf_take) begin
        buf_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      buf_word <= in_word;
    end
  end

  // at most one lane offered
  a_valid_oh: assert property (@(posedge clk) disable iff (rst)
    $onehot0(lane_valid));

endmodule

`default_nettype wire

// ==== hw/lane_unit.sv ====
/*
 * One transform lane. Buffers routed words in a small FIFO, eats
 * config words at the head to load the mode, and offers data words
 * with the current transform applied combinationally.
 */

`timescale 1ns/1ps
`default_nettype none

`include "xlane_cfg.svh"

module lane_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                word_valid,
  output logic                word_ready,
  input  word_pkg::in_word_t  word,
  output logic                beat_valid,
  input  logic                beat_ready,
  output lane_pkg::lane_beat_t beat
);

  import word_pkg::*;
  import lane_pkg::*;

  localparam int DEPTH = `XLANE_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int PW    = `XLANE_PAYLOAD_W;

  in_word_t              mem [DEPTH];
  logic [AW:0]           wr_ptr;
  logic [AW:0]           rd_ptr;
  logic                  empty;
  logic                  full;
  logic                  push;
  logic                  pop;
  in_word_t              head;
  logic                  head_cfg;
  xform_mode_t           mode;
  logic [PW-3:0]         const_val;
  logic [PW-1:0]         const_ext;
  logic [PW-1:0]         xdata;

  ////////////////////////////////
  // FIFO

  // extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

  assign word_ready = ~full;
  assign push       = word_valid & word_ready;

  assign head     = mem[rd_ptr[AW-1:0]];
  assign head_cfg = ~empty & head.is_cfg;

  // config at head leaves without a handshake
  assign beat_valid = ~empty & ~head.is_cfg;
  assign pop        = head_cfg | (beat_valid & beat_ready);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////
  // mode register

  always_ff @(posedge clk) begin
    if (rst) begin
      mode      <= MODE_PASS;
      const_val <= '0;
    end else if (head_cfg) begin
      mode      <= head.body.cfg.mode;
      const_val <= head.body.cfg.const_val;
    end
  end

  ////////////////////////////////
  // transform

  assign const_ext = PW'(const_val);

  always_comb begin
    case (mode)
      MODE_XOR: xdata = head.body.data.payload ^ const_ext;
      // wraps at payload width
      MODE_ADD: xdata = head.body.data.payload + const_ext;
      MODE_INV: xdata = ~head.body.data.payload;
      default:  xdata = head.body.data.payload;
    endcase
  end

  assign beat = '{data: xdata};

  // a word refused by the full FIFO is offered again unchanged
  a_full_hold: assert property (@(posedge clk) disable iff (rst)
    (word_valid && full) |=> word_valid && $stable(word));

endmodule

`default_nettype wire

// ==== hw/word_pkg.sv ====
/*
 * Input word formats for the multi-lane transformer.
 * One 19-bit word carries either lane data or a lane mode update.
 */

`default_nettype none

`include "xlane_cfg.svh"

package word_pkg;

  // transform applied by a lane to its data words
  typedef enum logic [1:0] {
    MODE_PASS = 2'd0,
    MODE_XOR  = 2'd1,
    MODE_ADD  = 2'd2,
    MODE_INV  = 2'd3
  } xform_mode_t;

  // data body, payload only
  typedef struct packed {
    logic [`XLANE_PAYLOAD_W-1:0] payload;
  } data_body_t;

  // config body, mode on top of a short constant
  // constant zero-extended to payload width when used
  typedef struct packed {
    xform_mode_t                 mode;
    logic [`XLANE_PAYLOAD_W-3:0] const_val;
  } cfg_body_t;

  // same 16 bits, read by is_cfg
  typedef union packed {
    data_body_t data;
    cfg_body_t  cfg;
  } word_body_u;

  typedef struct packed {
    logic                     is_cfg;
    logic [`XLANE_LANE_W-1:0] lane;
    word_body_u               body;
  } in_word_t;

endpackage

`default_nettype wire

// ==== hw/xlane_top.sv ====
/*
 * Top level of the multi-lane word transformer.
 * Input words go through the router, one lane each, then the merge.
 */

`timescale 1ns/1ps
`default_nettype none

`include "xlane_cfg.svh"

module xlane_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  word_pkg::in_word_t           in_word,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic [`XLANE_PAYLOAD_W-1:0]  out_data,
  output lane_pkg::lane_oh_t           out_lane
);

  import word_pkg::*;
  import lane_pkg::*;

  // router to lanes
  lane_oh_t   lane_valid;
  lane_oh_t   lane_ready;
  in_word_t   lane_word;

  // lanes to merge
  lane_oh_t                               beat_valid;
  lane_oh_t                               beat_ready;
  lane_beat_t [`XLANE_NUM_LANES-1:0]      beats;

  lane_steer u_steer (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_word    (in_word),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .lane_word  (lane_word)
  );

  ////////////////////////////////
  // lanes, all share the routed word

  for (genvar g = 0; g < `XLANE_NUM_LANES; g++) begin : g_lane
    lane_unit u_lane (
      .clk        (clk),
      .rst        (rst),
      .word_valid (lane_valid[g]),
      .word_ready (lane_ready[g]),
      .word       (lane_word),
      .beat_valid (beat_valid[g]),
      .beat_ready (beat_ready[g]),
      .beat       (beats[g])
    );
  end

  lane_merge u_merge (
    .clk        (clk),
    .rst        (rst),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beats      (beats),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_lane   (out_lane)
  );

endmodule

`default_nettype wire

// ==== include/xlane_cfg.svh ====
/*
 * Build-time sizing for the multi-lane word transformer.
 * Include in any file that sizes ports, types or storage.
 */

`ifndef XLANE_CFG_SVH
`define XLANE_CFG_SVH

// number of lanes behind the steering stage
`define XLANE_NUM_LANES 4

// data payload width of every word and beat
`define XLANE_PAYLOAD_W 16

// words per lane FIFO, power of two
`define XLANE_FIFO_DEPTH 4

// width of the lane field in an input word
`define XLANE_LANE_W 2

`endif

// ==== tb/tb_xlane.sv ====
/*
 * Testbench for xlane_top. Replays words from the trace file with
 * random input gaps and random output stalls, and checks every output
 * word against the per-lane expected lists from the same file.
 */

`timescale 1ns/1ps
`default_nettype none

`include "xlane_cfg.svh"

module tb_xlane;

  import word_pkg::*;
  import lane_pkg::*;

  localparam int NL        = `XLANE_NUM_LANES;
  localparam int MAX_WORDS = 256;
  localparam int IN_WAIT   = 500;
  localparam int DRAIN_MAX = 2000;

  logic                        clk;
  logic                        rst;
  logic                        in_valid;
  logic                        in_ready;
  in_word_t                    in_word;
  logic                        out_valid;
  logic                        out_ready;
  logic [`XLANE_PAYLOAD_W-1:0] out_data;
  lane_oh_t                    out_lane;

  // stimulus and expected lists
  logic [18:0] stim_mem [MAX_WORDS];
  int          n_stim;
  logic [15:0] exp_mem [NL][MAX_WORDS];
  int          exp_cnt [NL];
  int          exp_rd [NL];

  int          seed = 32'h39f4;
  int          stall_left;
  logic        in_fire;

  xlane_top dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_word   (in_word),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_lane  (out_lane)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////
  // helpers

  task automatic stop_with_error();
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      stop_with_error();
    end
  endtask

  function automatic int lane_of(input lane_oh_t oh);
    int idx;
    idx = 0;
    for (int i = 0; i < NL; i++) begin
      if (oh[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic logic all_drained();
    logic done;
    done = 1'b1;
    for (int i = 0; i < NL; i++) begin
      if (exp_rd[i] != exp_cnt[i]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic load_trace();
    int    fd;
    int    lane;
    string line;
    logic [31:0] val;
    fd = $fopen("tb/xlane_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tb/xlane_trace.txt");
      stop_with_error();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "s %h", val) == 1) begin
          stim_mem[n_stim] = val[18:0];
          n_stim++;
        end else if ($sscanf(line, "e %d %h", lane, val) == 2) begin
          if (lane < 0 || lane >= NL) begin
            $display("trace names lane %0d, which does not exist", lane);
            stop_with_error();
          end
          exp_mem[lane][exp_cnt[lane]] = val[15:0];
          exp_cnt[lane]++;
        end
      end
    end
    $fclose(fd);
  endtask

  // long stalls now and then but mostly ready
  task automatic drive_ready();
    logic [31:0] r;
    r = $random(seed);
    if (stall_left > 0) begin
      out_ready  = 1'b0;
      stall_left--;
    end else if (r[3:0] == 4'd0) begin
      out_ready  = 1'b0;
      stall_left = 10 + int'(r[8:4]);
    end else begin
      out_ready = (r[5:4] != 2'd0);
    end
  endtask

  ////////////////////////////////
  // output monitor

  task automatic take_output();
    int lane;
    lane = lane_of(out_lane);
    check_value("out_lane_onehot", 32'($onehot(out_lane)), 32'd1);
    if (exp_rd[lane] >= exp_cnt[lane]) begin
      $display("output word %h arrived on lane %0d with nothing expected",
               out_data, lane);
      stop_with_error();
    end
    check_value("out_data", 32'(out_data), 32'(exp_mem[lane][exp_rd[lane]]));
    exp_rd[lane]++;
  endtask

  always @(posedge clk) begin
    in_fire = in_valid && in_ready;
    if (!rst && out_valid && out_ready) begin
      take_output();
    end
  end

  ////////////////////////////////
  // main sequence

  initial begin
    int idx;
    int stuck;
    int drain;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_word    = '0;
    out_ready  = 1'b0;
    n_stim     = 0;
    stall_left = 0;
    in_fire    = 1'b0;
    for (int i = 0; i < NL; i++) begin
      exp_cnt[i] = 0;
      exp_rd[i]  = 0;
    end
    load_trace();

    // quiet outputs and no input room during reset
    repeat (5) begin
      @(negedge clk);
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("in_ready", 32'(in_ready), 32'd0);
    end
    rst = 1'b0;
    @(negedge clk);
    check_value("out_valid", 32'(out_valid), 32'd0);

    // random gaps in the first half and none after
    idx   = 0;
    stuck = 0;
    while (idx < n_stim) begin
      @(negedge clk);
      drive_ready();
      if (in_valid && !in_fire) begin
        stuck++;
        if (stuck > IN_WAIT) begin
          $display("timeout waiting for in_ready on stimulus word %0d", idx);
          stop_with_error();
        end
      end else begin
        if (in_valid) begin
          idx++;
        end
        stuck    = 0;
        in_valid = 1'b0;
        if (idx < n_stim) begin
          if (!(idx < n_stim / 2 && ($random(seed) & 3) == 0)) begin
            in_valid = 1'b1;
            in_word  = stim_mem[idx];
          end
        end
      end
    end

    // let every lane drain
    drain = 0;
    while (!all_drained()) begin
      @(negedge clk);
      drive_ready();
      drain++;
      if (drain > DRAIN_MAX) begin
        $display("timeout waiting for the lanes to deliver all expected words");
        stop_with_error();
      end
    end

    repeat (4) @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/xlane_trace.txt ====
# s <word>: 19-bit input word in hex (is_cfg, lane[1:0], body[15:0])
# e <lane> <data>: expected 16-bit output of that lane in hex, in lane order
# phase one, with input gaps: pass before config, then per-lane modes
s 01234
e 0 1234
s 1abcd
e 1 abcd
s 540ff
s 11234
e 1 12cb
s 68010
s 2fff8
e 2 0008
s 7c000
s 30f0f
e 3 f0f0
s 05555
e 0 5555
s 5bfff
s 10001
e 1 4000
s 30000
e 3 ffff
s 21234
e 2 1244
s 46aaa
s 0ffff
e 0 d555
s 1fff0
e 1 3fef
# phase two, back to back across all lanes
s 00000
e 0 2aaa
s 1c000
e 1 ffff
s 2fff0
e 2 0000
s 3aaaa
e 3 5555
s 02aaa
e 0 0000
s 18000
e 1 bfff
s 20005
e 2 0015
s 3ffff
e 3 0000
